//--- list.f
+incdir+logic
logic/i3c_pkg.sv
logic/controller_pkg.sv
logic/bus_monitor.sv
logic/controller_standby_i2c.sv
logic/controller_standby_i3c.sv
logic/controller_standby.sv
logic/tti_queue.sv
logic/standby_csr.sv
logic/standby_top.sv
sim/standby_tb.sv

//--- logic/bus_monitor.sv
// Bus condition detector for one SCL/SDA pair, instantiated once inside each target
`timescale 1ns/1ns
`default_nettype none

module bus_monitor
  import i3c_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  bus_in_t  bus_i,
  output bus_evt_t evt_o
);

  bus_in_t sync1_q;
  bus_in_t sync2_q;
  bus_in_t prev_q;

  // Two-flop synchronizer, then registered edge detection
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync1_q <= '1;
      sync2_q <= '1;
      prev_q  <= '1;
      evt_o   <= '0;
    end else begin
      sync1_q <= bus_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      evt_o.start    <= prev_q.scl & sync2_q.scl & prev_q.sda & ~sync2_q.sda;
      evt_o.stop     <= prev_q.scl & sync2_q.scl & ~prev_q.sda & sync2_q.sda;
      evt_o.scl_rise <= ~prev_q.scl & sync2_q.scl;
      evt_o.scl_fall <= prev_q.scl & ~sync2_q.scl;
      evt_o.sda      <= sync2_q.sda;
    end
  end

endmodule

`default_nettype wire

//--- logic/controller_pkg.sv
// TTI record and configuration types used by the targets, queues and register block
`default_nettype none

`include "standby_defs.svh"

package controller_pkg;

  typedef struct packed {
    logic [7:0] byte_count;
    logic       is_i3c;
    logic       parity_err;
    logic [5:0] reserved;
  } rx_desc_t;

  // Little-endian payload word, first byte in bits 7:0
  typedef logic [`TTI_DATA_W-1:0] rx_data_t;

  typedef struct packed {
    logic       i2c_en;
    logic       i3c_en;
    logic [6:0] static_addr;
    logic [6:0] dynamic_addr;
  } standby_cfg_t;

  // Write side of both TTI queues
  typedef struct packed {
    logic     desc_valid;
    rx_desc_t desc;
    logic     data_valid;
    rx_data_t data;
  } tti_push_t;

endpackage

`default_nettype wire

//--- logic/controller_standby.sv
// Standby controller holding the I2C and I3C targets and selecting whose pushes reach the TTI
`timescale 1ns/1ns
`default_nettype none

module controller_standby
  import i3c_pkg::*;
  import controller_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  input  standby_cfg_t cfg_i,
  input  bus_in_t      bus_i [2],
  output bus_out_t     bus_o [2],
  output tti_push_t    push_o
);

  tti_push_t i2c_push;
  tti_push_t i3c_push;

  // I3C owns the TTI whenever it is enabled
  assign push_o = cfg_i.i3c_en ? i3c_push : i2c_push;

  // Bus 0 is I2C
  controller_standby_i2c u_standby_i2c (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .en_i   (cfg_i.i2c_en),
    .addr_i (cfg_i.static_addr),
    .bus_i  (bus_i[0]),
    .bus_o  (bus_o[0]),
    .push_o (i2c_push)
  );

  // Bus 1 is I3C
  controller_standby_i3c u_standby_i3c (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .en_i   (cfg_i.i3c_en),
    .addr_i (cfg_i.dynamic_addr),
    .bus_i  (bus_i[1]),
    .bus_o  (bus_o[1]),
    .push_o (i3c_push)
  );

endmodule

`default_nettype wire

//--- logic/controller_standby_i2c.sv
// I2C write target on the static address, turning received bytes into TTI pushes
`timescale 1ns/1ns
`default_nettype none

module controller_standby_i2c
  import i3c_pkg::*;
  import controller_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       en_i,
  input  logic [6:0] addr_i,
  input  bus_in_t    bus_i,
  output bus_out_t   bus_o,
  output tti_push_t  push_o
);

  typedef enum logic [2:0] {
    IDLE,
    ADDR,
    ACK,
    DATA,
    DACK
  } state_e;

  state_e     state_q;
  bus_evt_t   evt;
  logic [3:0] bit_cnt_q;
  logic [7:0] shift_q;
  logic [7:0] byte_cnt_q;
  rx_data_t   word_q;
  rx_data_t   word_d;
  logic       desc_pend_q;
  tti_push_t  push_q;
  logic [7:0] rx_byte;
  logic       addr_hit;

  bus_monitor u_bus_monitor (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .bus_i  (bus_i),
    .evt_o  (evt)
  );

  assign rx_byte  = {shift_q[6:0], evt.sda};
  // Write bit must be 0
  assign addr_hit = (shift_q[7:1] == addr_i) && !shift_q[0];

  // Current word with the byte just completed merged in
  always_comb begin
    word_d = word_q;
    word_d[byte_cnt_q[1:0]*8 +: 8] = rx_byte;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= IDLE;
      bit_cnt_q   <= '0;
      shift_q     <= '0;
      byte_cnt_q  <= '0;
      word_q      <= '0;
      desc_pend_q <= 1'b0;
      push_q      <= '0;
    end else begin
      push_q.data_valid <= 1'b0;
      push_q.desc_valid <= desc_pend_q;
      desc_pend_q       <= 1'b0;
      if (!en_i) begin
        state_q <= IDLE;
      end else if (evt.start) begin
        state_q    <= ADDR;
        bit_cnt_q  <= '0;
        byte_cnt_q <= '0;
        word_q     <= '0;
      end else if (evt.stop) begin
        // Flush partial word now, descriptor follows next cycle
        if (state_q == DATA || state_q == DACK) begin
          push_q.data_valid <= byte_cnt_q[1:0] != 2'd0;
          push_q.data       <= word_q;
          push_q.desc       <= '{byte_count: byte_cnt_q, is_i3c: 1'b0,
                                 parity_err: 1'b0, reserved: '0};
          desc_pend_q       <= 1'b1;
        end
        state_q <= IDLE;
      end else begin
        case (state_q)
          ADDR: begin
            if (evt.scl_rise && bit_cnt_q != 4'd8) begin
              shift_q   <= rx_byte;
              bit_cnt_q <= bit_cnt_q + 4'd1;
            end else if (evt.scl_fall && bit_cnt_q == 4'd8) begin
              state_q <= addr_hit ? ACK : IDLE;
            end
          end
          ACK, DACK: begin
            if (evt.scl_fall) begin
              state_q   <= DATA;
              bit_cnt_q <= '0;
            end
          end
          DATA: begin
            if (evt.scl_rise && bit_cnt_q != 4'd8) begin
              shift_q   <= rx_byte;
              bit_cnt_q <= bit_cnt_q + 4'd1;
              if (bit_cnt_q == 4'd7) begin
                word_q     <= word_d;
                byte_cnt_q <= byte_cnt_q + 8'd1;
                if (byte_cnt_q[1:0] == 2'd3) begin
                  push_q.data_valid <= 1'b1;
                  push_q.data       <= word_d;
                  word_q            <= '0;
                end
              end
            end else if (evt.scl_fall && bit_cnt_q == 4'd8) begin
              state_q <= DACK;
            end
          end
          default: ;
        endcase
      end
    end
  end

  assign bus_o.scl_drive_low = 1'b0;
  assign bus_o.sda_drive_low = (state_q == ACK) || (state_q == DACK);
  assign push_o              = push_q;

endmodule

`default_nettype wire

//--- logic/controller_standby_i3c.sv
// I3C private-write target on the dynamic address, checking T-bits and pushing TTI records
`timescale 1ns/1ns
`default_nettype none

module controller_standby_i3c
  import i3c_pkg::*;
  import controller_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       en_i,
  input  logic [6:0] addr_i,
  input  bus_in_t    bus_i,
  output bus_out_t   bus_o,
  output tti_push_t  push_o
);

  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    ACK,
    DATA
  } state_e;

  state_e     state_q;
  bus_evt_t   evt;
  logic [3:0] bit_cnt_q;
  logic [7:0] shift_q;
  logic [7:0] byte_cnt_q;
  rx_data_t   word_q;
  rx_data_t   word_d;
  logic       par_err_q;
  logic       desc_pend_q;
  tti_push_t  push_q;
  logic [7:0] rx_byte;
  logic       addr_hit;

  bus_monitor u_bus_monitor (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .bus_i  (bus_i),
    .evt_o  (evt)
  );

  assign rx_byte  = {shift_q[6:0], evt.sda};
  assign addr_hit = (shift_q[7:1] == addr_i) && !shift_q[0];

  always_comb begin
    word_d = word_q;
    word_d[byte_cnt_q[1:0]*8 +: 8] = rx_byte;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= IDLE;
      bit_cnt_q   <= '0;
      shift_q     <= '0;
      byte_cnt_q  <= '0;
      word_q      <= '0;
      par_err_q   <= 1'b0;
      desc_pend_q <= 1'b0;
      push_q      <= '0;
    end else begin
      push_q.data_valid <= 1'b0;
      push_q.desc_valid <= desc_pend_q;
      desc_pend_q       <= 1'b0;
      if (!en_i) begin
        state_q <= IDLE;
      end else if (evt.start) begin
        state_q    <= ADDR;
        bit_cnt_q  <= '0;
        byte_cnt_q <= '0;
        word_q     <= '0;
        par_err_q  <= 1'b0;
      end else if (evt.stop) begin
        if (state_q == DATA) begin
          push_q.data_valid <= byte_cnt_q[1:0] != 2'd0;
          push_q.data       <= word_q;
          push_q.desc       <= '{byte_count: byte_cnt_q, is_i3c: 1'b1,
                                 parity_err: par_err_q, reserved: '0};
          desc_pend_q       <= 1'b1;
        end
        state_q <= IDLE;
      end else begin
        case (state_q)
          ADDR: begin
            if (evt.scl_rise && bit_cnt_q != 4'd8) begin
              shift_q   <= rx_byte;
              bit_cnt_q <= bit_cnt_q + 4'd1;
            end else if (evt.scl_fall && bit_cnt_q == 4'd8) begin
              state_q <= addr_hit ? ACK : IDLE;
            end
          end
          ACK: begin
            if (evt.scl_fall) begin
              state_q   <= DATA;
              bit_cnt_q <= '0;
            end
          end
          DATA: begin
            if (evt.scl_rise && bit_cnt_q == 4'd8) begin
              // T-bit makes the nine bits odd
              bit_cnt_q <= '0;
              if (!(^{shift_q, evt.sda})) begin
                par_err_q <= 1'b1;
              end
            end else if (evt.scl_rise) begin
              shift_q   <= rx_byte;
              bit_cnt_q <= bit_cnt_q + 4'd1;
              if (bit_cnt_q == 4'd7) begin
                word_q     <= word_d;
                byte_cnt_q <= byte_cnt_q + 8'd1;
                if (byte_cnt_q[1:0] == 2'd3) begin
                  push_q.data_valid <= 1'b1;
                  push_q.data       <= word_d;
                  word_q            <= '0;
                end
              end
            end
          end
          default: ;
        endcase
      end
    end
  end

  // Only the address is acked, T-bits are driven by the host
  assign bus_o.scl_drive_low = 1'b0;
  assign bus_o.sda_drive_low = state_q == ACK;
  assign push_o              = push_q;

endmodule

`default_nettype wire

//--- logic/i3c_pkg.sv
// Bus-level types shared by the bus monitor, both targets and the top level
`default_nettype none

package i3c_pkg;

  // Line levels as seen on one bus
  typedef struct packed {
    logic scl;
    logic sda;
  } bus_in_t;

  // Open-drain pull-down enables
  typedef struct packed {
    logic scl_drive_low;
    logic sda_drive_low;
  } bus_out_t;

  // Synchronized bus conditions, one cycle each
  typedef struct packed {
    logic start;
    logic stop;
    logic scl_rise;
    logic scl_fall;
    logic sda;
  } bus_evt_t;

endpackage

`default_nettype wire

//--- logic/standby_csr.sv
// APB register block with the target enables, addresses and TTI drop counters
`timescale 1ns/1ns
`default_nettype none

`include "standby_defs.svh"

module standby_csr
  import controller_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   apb_psel_i,
  input  logic                   apb_penable_i,
  input  logic                   apb_pwrite_i,
  input  logic [`APB_ADDR_W-1:0] apb_paddr_i,
  input  logic [`APB_DATA_W-1:0] apb_pwdata_i,
  output logic [`APB_DATA_W-1:0] apb_prdata_o,
  output logic                   apb_pready_o,
  output logic                   apb_pslverr_o,
  input  logic                   desc_drop_i,
  input  logic                   data_drop_i,
  output standby_cfg_t           cfg_o
);

  standby_cfg_t cfg_q;
  logic [7:0]   desc_drops_q;
  logic [7:0]   data_drops_q;
  logic         wr;
  logic         hit_ctrl;
  logic         hit_addr;
  logic         hit_status;

  assign wr         = apb_psel_i & apb_penable_i & apb_pwrite_i;
  assign hit_ctrl   = apb_paddr_i == `CSR_CTRL;
  assign hit_addr   = apb_paddr_i == `CSR_ADDR;
  assign hit_status = apb_paddr_i == `CSR_STATUS;

  // No wait states
  assign apb_pready_o  = 1'b1;
  assign apb_pslverr_o = apb_psel_i & apb_penable_i & ~(hit_ctrl | hit_addr | hit_status);
  assign cfg_o         = cfg_q;

  always_comb begin
    apb_prdata_o = '0;
    if (hit_ctrl) begin
      apb_prdata_o[1:0] = {cfg_q.i3c_en, cfg_q.i2c_en};
    end else if (hit_addr) begin
      apb_prdata_o[14:0] = {cfg_q.dynamic_addr, 1'b0, cfg_q.static_addr};
    end else if (hit_status) begin
      apb_prdata_o[15:0] = {data_drops_q, desc_drops_q};
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cfg_q        <= '0;
      desc_drops_q <= '0;
      data_drops_q <= '0;
    end else begin
      if (wr && hit_ctrl) begin
        cfg_q.i2c_en <= apb_pwdata_i[0];
        cfg_q.i3c_en <= apb_pwdata_i[1];
      end
      if (wr && hit_addr) begin
        cfg_q.static_addr  <= apb_pwdata_i[6:0];
        cfg_q.dynamic_addr <= apb_pwdata_i[14:8];
      end
      // Clearing wins over a drop in the same cycle
      if (wr && hit_status) begin
        desc_drops_q <= '0;
        data_drops_q <= '0;
      end else begin
        if (desc_drop_i && desc_drops_q != 8'hff) begin
          desc_drops_q <= desc_drops_q + 8'd1;
        end
        if (data_drop_i && data_drops_q != 8'hff) begin
          data_drops_q <= data_drops_q + 8'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/standby_defs.svh
// Queue sizing, APB widths and register offsets of the standby receive path, included by users
`ifndef STANDBY_DEFS_SVH
`define STANDBY_DEFS_SVH

// TTI queue sizing
`define TTI_DEPTH 4
`define TTI_DATA_W 32

// APB bus widths
`define APB_ADDR_W 12
`define APB_DATA_W 32

// Register offsets
`define CSR_CTRL 12'h000
`define CSR_ADDR 12'h004
`define CSR_STATUS 12'h008

`endif

//--- logic/standby_top.sv
// Top of the standby receive subsystem, joining registers, controller and the two RX queues
`timescale 1ns/1ns
`default_nettype none

`include "standby_defs.svh"

module standby_top
  import i3c_pkg::*;
  import controller_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   apb_psel_i,
  input  logic                   apb_penable_i,
  input  logic                   apb_pwrite_i,
  input  logic [`APB_ADDR_W-1:0] apb_paddr_i,
  input  logic [`APB_DATA_W-1:0] apb_pwdata_i,
  output logic [`APB_DATA_W-1:0] apb_prdata_o,
  output logic                   apb_pready_o,
  output logic                   apb_pslverr_o,
  input  bus_in_t                bus_i [2],
  output bus_out_t               bus_o [2],
  output logic                   rx_desc_valid_o,
  input  logic                   rx_desc_ready_i,
  output rx_desc_t               rx_desc_o,
  output logic                   rx_data_valid_o,
  input  logic                   rx_data_ready_i,
  output rx_data_t               rx_data_o
);

  standby_cfg_t cfg;
  tti_push_t    push;
  logic         desc_drop;
  logic         data_drop;

  standby_csr u_csr (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .apb_psel_i   (apb_psel_i),
    .apb_penable_i(apb_penable_i),
    .apb_pwrite_i (apb_pwrite_i),
    .apb_paddr_i  (apb_paddr_i),
    .apb_pwdata_i (apb_pwdata_i),
    .apb_prdata_o (apb_prdata_o),
    .apb_pready_o (apb_pready_o),
    .apb_pslverr_o(apb_pslverr_o),
    .desc_drop_i  (desc_drop),
    .data_drop_i  (data_drop),
    .cfg_o        (cfg)
  );

  controller_standby u_controller (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .cfg_i  (cfg),
    .bus_i  (bus_i),
    .bus_o  (bus_o),
    .push_o (push)
  );

  tti_queue #(
    .entry_t(rx_desc_t)
  ) u_desc_queue (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .push_i     (push.desc_valid),
    .push_data_i(push.desc),
    .drop_o     (desc_drop),
    .rvalid_o   (rx_desc_valid_o),
    .rready_i   (rx_desc_ready_i),
    .rdata_o    (rx_desc_o)
  );

  tti_queue #(
    .entry_t(rx_data_t)
  ) u_data_queue (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .push_i     (push.data_valid),
    .push_data_i(push.data),
    .drop_o     (data_drop),
    .rvalid_o   (rx_data_valid_o),
    .rready_i   (rx_data_ready_i),
    .rdata_o    (rx_data_o)
  );

endmodule

`default_nettype wire

//--- logic/tti_queue.sv
// TTI receive queue for any entry type, dropping pushes when full, read through valid/ready
`timescale 1ns/1ns
`default_nettype none

`include "standby_defs.svh"

module tti_queue #(
  parameter type entry_t = logic [`TTI_DATA_W-1:0]
) (
  input  logic   clk_i,
  input  logic   reset_i,
  input  logic   push_i,
  input  entry_t push_data_i,
  output logic   drop_o,
  output logic   rvalid_o,
  input  logic   rready_i,
  output entry_t rdata_o
);

  localparam int unsigned ptr_w = $clog2(`TTI_DEPTH);

  entry_t           mem [`TTI_DEPTH];
  logic [ptr_w-1:0] wptr_q;
  logic [ptr_w-1:0] rptr_q;
  logic [ptr_w:0]   count_q;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign full     = count_q == (ptr_w + 1)'(`TTI_DEPTH);
  assign do_push  = push_i & ~full;
  assign do_pop   = rvalid_o & rready_i;
  assign drop_o   = push_i & full;
  assign rvalid_o = count_q != '0;
  assign rdata_o  = mem[rptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (do_pop) begin
        rptr_q <= rptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Builds the standby testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -f list.f --top-module standby_tb \
  -Mdir build -o standby_sim > build.log 2>&1 \
  && ./build/standby_sim > sim.log 2>&1 \
  || { cat build.log; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "ALL CHECKS PASSED" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- sim/standby_tb.sv
// Testbench for the standby receive top; drives APB and both buses, checks the RX queues
`timescale 1ns/1ns
`default_nettype none

`include "standby_defs.svh"

module standby_tb
  import i3c_pkg::*;
  import controller_pkg::*;
();

  localparam int bit_clocks = 16;
  localparam int max_bytes = 9;
  localparam int num_transfers = 16;
  // Start, address and data bytes with ninth bit, stop and bus free time
  localparam int transfer_clocks = ((max_bytes + 1) * 9 + 4) * bit_clocks;
  localparam int limit_clocks = num_transfers * transfer_clocks + 4000;

  logic                   clk;
  logic                   reset;
  logic                   apb_psel;
  logic                   apb_penable;
  logic                   apb_pwrite;
  logic [`APB_ADDR_W-1:0] apb_paddr;
  logic [`APB_DATA_W-1:0] apb_pwdata;
  logic [`APB_DATA_W-1:0] apb_prdata;
  logic                   apb_pready;
  logic                   apb_pslverr;
  logic [1:0]             host_scl;
  logic [1:0]             host_sda;
  bus_in_t                bus_in [2];
  bus_out_t               bus_out [2];
  logic                   rx_desc_valid;
  logic                   rx_desc_ready;
  rx_desc_t               rx_desc;
  logic                   rx_data_valid;
  logic                   rx_data_ready;
  rx_data_t               rx_data;

  rx_desc_t   exp_desc_q [$];
  rx_data_t   exp_data_q [$];
  logic [7:0] payload [max_bytes];
  logic       i2c_en;
  logic       i3c_en;
  logic [6:0] static_addr;
  logic [6:0] dynamic_addr;
  logic       hold_mode;
  int         held_desc;
  int         held_data;
  int         exp_desc_drops;
  int         exp_data_drops;
  int         desc_pops;
  int         data_pops;
  int         apb_errors;
  int         bus_errors;
  int         queue_errors;

  always #20 clk = ~clk;

  // Open-drain lines, wired AND of host and target
  always_comb begin
    for (int k = 0; k < 2; k++) begin
      bus_in[k].scl = host_scl[k] & ~bus_out[k].scl_drive_low;
      bus_in[k].sda = host_sda[k] & ~bus_out[k].sda_drive_low;
    end
  end

  standby_top dut0 (
    .clk_i          (clk),
    .reset_i        (reset),
    .apb_psel_i     (apb_psel),
    .apb_penable_i  (apb_penable),
    .apb_pwrite_i   (apb_pwrite),
    .apb_paddr_i    (apb_paddr),
    .apb_pwdata_i   (apb_pwdata),
    .apb_prdata_o   (apb_prdata),
    .apb_pready_o   (apb_pready),
    .apb_pslverr_o  (apb_pslverr),
    .bus_i          (bus_in),
    .bus_o          (bus_out),
    .rx_desc_valid_o(rx_desc_valid),
    .rx_desc_ready_i(rx_desc_ready),
    .rx_desc_o      (rx_desc),
    .rx_data_valid_o(rx_data_valid),
    .rx_data_ready_i(rx_data_ready),
    .rx_data_o      (rx_data)
  );

  task automatic wait_clocks(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic apb_write(input logic [`APB_ADDR_W-1:0] addr,
                           input logic [`APB_DATA_W-1:0] data);
    apb_psel    <= 1'b1;
    apb_penable <= 1'b0;
    apb_pwrite  <= 1'b1;
    apb_paddr   <= addr;
    apb_pwdata  <= data;
    @(posedge clk);
    apb_penable <= 1'b1;
    @(posedge clk);
    apb_psel    <= 1'b0;
    apb_penable <= 1'b0;
    apb_pwrite  <= 1'b0;
  endtask

  task automatic apb_check_read(input logic [`APB_ADDR_W-1:0] addr,
                                input logic [`APB_DATA_W-1:0] exp_data,
                                input logic exp_err);
    logic [`APB_DATA_W-1:0] data;
    logic                   err;
    logic                   rdy;
    apb_psel    <= 1'b1;
    apb_penable <= 1'b0;
    apb_pwrite  <= 1'b0;
    apb_paddr   <= addr;
    @(posedge clk);
    apb_penable <= 1'b1;
    // Access phase, sampled mid-cycle
    @(negedge clk);
    data = apb_prdata;
    err  = apb_pslverr;
    rdy  = apb_pready;
    @(posedge clk);
    apb_psel    <= 1'b0;
    apb_penable <= 1'b0;
    if (data !== exp_data) begin
      $display("error apb_prdata_o at %h: got %h, expected %h", addr, data, exp_data);
      apb_errors++;
    end
    if (err !== exp_err) begin
      $display("error apb_pslverr_o at %h: got %h, expected %h", addr, err, exp_err);
      apb_errors++;
    end
    // No wait states, so the access phase always completes
    if (rdy !== 1'b1) begin
      $display("error apb_pready_o at %h: got %h, expected %h", addr, rdy, 1'b1);
      apb_errors++;
    end
  endtask

  task automatic set_ctrl(input logic i2c, input logic i3c);
    i2c_en = i2c;
    i3c_en = i3c;
    apb_write(`CSR_CTRL, {30'd0, i3c, i2c});
  endtask

  task automatic set_addr(input logic [6:0] sa, input logic [6:0] da);
    static_addr  = sa;
    dynamic_addr = da;
    apb_write(`CSR_ADDR, {17'd0, da, 1'b0, sa});
  endtask

  task automatic bus_start(input int k);
    host_sda[k] <= 1'b0;
    wait_clocks(8);
    host_scl[k] <= 1'b0;
  endtask

  task automatic send_bit(input int k, input logic b);
    wait_clocks(4);
    host_sda[k] <= b;
    wait_clocks(4);
    host_scl[k] <= 1'b1;
    wait_clocks(8);
    host_scl[k] <= 1'b0;
  endtask

  task automatic send_byte(input int k, input logic [7:0] b);
    for (int i = 7; i >= 0; i--) begin
      send_bit(k, b[i]);
    end
  endtask

  // Host releases SDA for the ninth clock and looks at it mid-high
  task automatic sample_ack(input int k, output logic ack_low);
    wait_clocks(4);
    host_sda[k] <= 1'b1;
    wait_clocks(4);
    host_scl[k] <= 1'b1;
    wait_clocks(6);
    @(negedge clk);
    ack_low = ~bus_in[k].sda;
    wait_clocks(2);
    host_scl[k] <= 1'b0;
  endtask

  task automatic bus_stop(input int k);
    wait_clocks(4);
    host_sda[k] <= 1'b0;
    wait_clocks(4);
    host_scl[k] <= 1'b1;
    wait_clocks(8);
    host_sda[k] <= 1'b1;
    wait_clocks(16);
  endtask

  task automatic check_ack(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error sda ack (%s): got %h, expected %h", what, got, exp);
      bus_errors++;
    end
  endtask

  function automatic int rand_len();
    return int'($urandom % 32'd9) + 1;
  endfunction

  // Queue capacity only matters while the readys are held low
  function automatic void model_push_desc(input rx_desc_t d);
    if (hold_mode && held_desc >= `TTI_DEPTH) begin
      exp_desc_drops++;
    end else begin
      exp_desc_q.push_back(d);
      if (hold_mode) begin
        held_desc++;
      end
    end
  endfunction

  function automatic void model_push_data(input rx_data_t w);
    if (hold_mode && held_data >= `TTI_DEPTH) begin
      exp_data_drops++;
    end else begin
      exp_data_q.push_back(w);
      if (hold_mode) begin
        held_data++;
      end
    end
  endfunction

  // Expected address ACK and TTI entries of one transfer
  function automatic logic model_transfer(input int k, input logic [6:0] addr,
                                          input logic rnw, input int n,
                                          input logic bad_tbit);
    logic     en;
    logic     match;
    logic     selected;
    rx_data_t word;
    rx_desc_t desc;
    en    = (k == 0) ? i2c_en : i3c_en;
    match = en && !rnw && (addr == ((k == 0) ? static_addr : dynamic_addr));
    // I3C owns the queues whenever it is enabled
    selected = (k == 1) ? i3c_en : !i3c_en;
    if (match && selected) begin
      word = '0;
      for (int i = 0; i < n; i++) begin
        word[(i % 4) * 8 +: 8] = payload[i];
        if (i % 4 == 3 || i == n - 1) begin
          model_push_data(word);
          word = '0;
        end
      end
      desc            = '0;
      desc.byte_count = 8'(n);
      desc.is_i3c     = (k == 1);
      desc.parity_err = (k == 1) && bad_tbit;
      model_push_desc(desc);
    end
    return match;
  endfunction

  task automatic run_transfer(input int k, input logic [6:0] addr, input logic rnw,
                              input int n, input logic bad_tbit);
    logic exp_ack;
    logic ack;
    logic tbit;
    for (int i = 0; i < max_bytes; i++) begin
      payload[i] = 8'($urandom);
    end
    exp_ack = model_transfer(k, addr, rnw, n, bad_tbit);
    bus_start(k);
    send_byte(k, {addr, rnw});
    sample_ack(k, ack);
    check_ack("address", ack, exp_ack);
    if (exp_ack) begin
      for (int i = 0; i < n; i++) begin
        send_byte(k, payload[i]);
        if (k == 0) begin
          sample_ack(k, ack);
          check_ack("data", ack, 1'b1);
        end else begin
          // Odd parity over byte and T-bit, broken on the last byte on request
          tbit = ~^payload[i];
          if (bad_tbit && i == n - 1) begin
            tbit = ~tbit;
          end
          send_bit(k, tbit);
        end
      end
    end
    bus_stop(k);
  endtask

  task automatic wait_drain();
    while (exp_desc_q.size() != 0 || exp_data_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  // Compares every entry that leaves a queue
  always @(negedge clk) begin
    if (!reset && rx_desc_valid && rx_desc_ready) begin
      desc_pops++;
      if (exp_desc_q.size() == 0) begin
        $display("unexpected descriptor %h left the queue", rx_desc);
        queue_errors++;
      end else begin
        if (rx_desc !== exp_desc_q[0]) begin
          $display("error rx_desc_o: got %h, expected %h", rx_desc, exp_desc_q[0]);
          queue_errors++;
        end
        void'(exp_desc_q.pop_front());
      end
    end
    if (!reset && rx_data_valid && rx_data_ready) begin
      data_pops++;
      if (exp_data_q.size() == 0) begin
        $display("unexpected data word %h left the queue", rx_data);
        queue_errors++;
      end else begin
        if (rx_data !== exp_data_q[0]) begin
          $display("error rx_data_o: got %h, expected %h", rx_data, exp_data_q[0]);
          queue_errors++;
        end
        void'(exp_data_q.pop_front());
      end
    end
  end

  initial begin
    repeat (limit_clocks) @(posedge clk);
    $display("timeout: run did not finish within %0d clocks", limit_clocks);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    int desc_base;
    int data_base;
    void'($urandom(32'hee0b_fddb));
    clk            = 1'b0;
    reset          = 1'b1;
    apb_psel       = 1'b0;
    apb_penable    = 1'b0;
    apb_pwrite     = 1'b0;
    apb_paddr      = '0;
    apb_pwdata     = '0;
    host_scl       = 2'b11;
    host_sda       = 2'b11;
    rx_desc_ready  = 1'b1;
    rx_data_ready  = 1'b1;
    i2c_en         = 1'b0;
    i3c_en         = 1'b0;
    static_addr    = '0;
    dynamic_addr   = '0;
    hold_mode      = 1'b0;
    held_desc      = 0;
    held_data      = 0;
    exp_desc_drops = 0;
    exp_data_drops = 0;
    desc_pops      = 0;
    data_pops      = 0;
    apb_errors     = 0;
    bus_errors     = 0;
    queue_errors   = 0;
    wait_clocks(4);
    reset <= 1'b0;
    wait_clocks(2);

    // Register access
    set_ctrl(1'b1, 1'b1);
    apb_check_read(`CSR_CTRL, 32'h3, 1'b0);
    set_addr(7'h2a, 7'h51);
    apb_check_read(`CSR_ADDR, {17'd0, 7'h51, 1'b0, 7'h2a}, 1'b0);
    apb_check_read(12'h010, '0, 1'b1);
    apb_check_read(`CSR_STATUS, '0, 1'b0);

    // I2C writes to the static address
    set_ctrl(1'b1, 1'b0);
    repeat (4) begin
      run_transfer(0, static_addr, 1'b0, rand_len(), 1'b0);
      wait_drain();
    end

    // Wrong address and a read get no ACK
    run_transfer(0, static_addr ^ 7'h01, 1'b0, 3, 1'b0);
    run_transfer(0, static_addr, 1'b1, 3, 1'b0);
    wait_drain();

    // I3C private writes, the last with a bad T-bit
    set_ctrl(1'b0, 1'b1);
    repeat (3) begin
      run_transfer(1, dynamic_addr, 1'b0, rand_len(), 1'b0);
    end
    run_transfer(1, dynamic_addr, 1'b0, rand_len(), 1'b1);
    wait_drain();

    // Overflow with both readys low
    rx_desc_ready <= 1'b0;
    rx_data_ready <= 1'b0;
    hold_mode = 1'b1;
    repeat (6) begin
      run_transfer(1, dynamic_addr, 1'b0, rand_len(), 1'b0);
    end
    apb_check_read(`CSR_STATUS, {16'd0, exp_data_drops[7:0], exp_desc_drops[7:0]}, 1'b0);
    desc_base = desc_pops;
    data_base = data_pops;
    hold_mode = 1'b0;
    rx_desc_ready <= 1'b1;
    rx_data_ready <= 1'b1;
    wait_drain();
    wait_clocks(16);
    if (desc_pops - desc_base != `TTI_DEPTH) begin
      $display("descriptor queue gave %0d entries after overflow", desc_pops - desc_base);
      queue_errors++;
    end
    if (data_pops - data_base != `TTI_DEPTH) begin
      $display("data queue gave %0d entries after overflow", data_pops - data_base);
      queue_errors++;
    end
    apb_write(`CSR_STATUS, '0);
    apb_check_read(`CSR_STATUS, '0, 1'b0);

    wait_clocks(32);
    if (rx_desc_valid || rx_data_valid) begin
      $display("entries left in the RX queues at the end of the run");
      queue_errors++;
    end
    $display("errors: apb %0d, bus %0d, queue %0d", apb_errors, bus_errors, queue_errors);
    if (apb_errors + bus_errors + queue_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
